//--- cache_pkg.sv
// shared widths and types for the data cache, imported by every cache module
package cache_pkg;

    //////////////////////////////
    // address and data geometry
    //////////////////////////////

    localparam int ADDR_W     = 20;
    localparam int TAG_W      = 16;                  // address bits 19 to 4
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / 8;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W; // 128 bit line
    localparam int WAY_IDX_W  = 3;                   // wide enough for up to 8 ways

    //////////////////////////////
    // data views
    //////////////////////////////

    // one stored word, seen either whole or as its four bytes
    typedef union packed {
        logic [WORD_W-1:0]          word;
        logic [WORD_BYTES-1:0][7:0] bytes;
    } data_word_u;

    //////////////////////////////
    // request and lookup verdict
    //////////////////////////////

    // decoded core request, strobes already qualified by the alignment check
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [1:0]        word_sel;   // word within the line
        logic [1:0]        byte_sel;   // byte within the word
        logic              byte_acc;
        logic              rd;
        logic              wr;
        logic [WORD_W-1:0] wdata;
    } cache_req_t;

    // lookup result that steers the data array
    typedef struct packed {
        logic                 read_hit;
        logic                 write_hit;
        logic [WAY_IDX_W-1:0] hit_way;
        logic                 refill;     // line from memory is written this cycle
        logic [WAY_IDX_W-1:0] refill_way;
    } lookup_res_t;

endpackage

//--- cache_addr_decode.sv
// request decoder of the data cache, slices the core address and drops unaligned word accesses
`timescale 1ns/100ps

module cache_addr_decode (
    input  logic                         read_rqst_i,
    input  logic                         write_enable_i,
    input  logic                         rqst_byte_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic [cache_pkg::WORD_W-1:0] wdata_i,
    output cache_pkg::cache_req_t        req_o,
    output logic                         unalign_o
);
    import cache_pkg::*;

    logic access;
    logic unalign;

    assign access  = read_rqst_i | write_enable_i;

    // a word access must sit on a word boundary, a byte access may not
    assign unalign = access & ~rqst_byte_i & (|addr_i[1:0]);

    //////////////////////////////
    // request fields
    //////////////////////////////

    always_comb begin
        req_o.tag      = addr_i[ADDR_W-1:ADDR_W-TAG_W];
        req_o.word_sel = addr_i[3:2];
        req_o.byte_sel = addr_i[1:0];
        req_o.byte_acc = rqst_byte_i;
        req_o.rd       = read_rqst_i & ~unalign;     // misaligned requests never reach lookup
        req_o.wr       = write_enable_i & ~unalign;
        req_o.wdata    = wdata_i;
    end

    assign unalign_o = unalign;

endmodule

//--- cache_lookup.sv
// tag lookup of the data cache with hit detection, the LRU age matrix and the miss/refill FSM
`timescale 1ns/100ps

module cache_lookup #(
    parameter int NUM_WAYS = 4
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  cache_pkg::cache_req_t        req_i,
    input  logic                         kill_i,
    input  logic                         mem_data_ready_i,
    input  logic [cache_pkg::ADDR_W-1:0] mem_addr_i,
    output cache_pkg::lookup_res_t       res_o,
    output logic                         read_miss_o,
    output logic                         rqst_to_mem_o,
    output logic [cache_pkg::ADDR_W-1:0] addr_to_mem_o
);
    import cache_pkg::*;

    localparam int   WAY_W   = $clog2(NUM_WAYS);
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic                state_q;
    logic [TAG_W-1:0]    tags_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q;
    logic [TAG_W-1:0]    miss_tag_q;
    logic [NUM_WAYS-1:0] lru_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] lru_d [NUM_WAYS];
    logic [NUM_WAYS-1:0] hit_vec;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim_way;
    logic [WAY_W-1:0]    mark_way;
    logic [TAG_W-1:0]    mem_tag;
    logic                idle;
    logic                any_hit;
    logic                read_hit;
    logic                write_hit;
    logic                read_miss;
    logic                fill;
    logic                mark_en;

    //////////////////////////////
    // tag compare
    //////////////////////////////

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tags_q[w] == req_i.tag);
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) hit_way = WAY_W'(w);       // lowest matching way wins
        end
    end

    assign idle      = (state_q == ST_IDLE);
    assign any_hit   = |hit_vec;
    assign read_hit  = idle & req_i.rd & any_hit;
    assign write_hit = idle & req_i.wr & any_hit;   // requests in wait are not serviced
    assign read_miss = req_i.rd & ~any_hit;
    assign mem_tag   = mem_addr_i[ADDR_W-1:ADDR_W-TAG_W];
    assign fill      = ~idle & ~kill_i & mem_data_ready_i & (mem_tag == miss_tag_q);

    //////////////////////////////
    // LRU age matrix
    //////////////////////////////

    // the row whose bits are all one is the oldest way
    always_comb begin
        victim_way = '0;
        for (int r = NUM_WAYS - 1; r >= 0; r--) begin
            if (&lru_q[r]) victim_way = WAY_W'(r);
        end
    end

    assign mark_en  = read_hit | write_hit | fill;
    assign mark_way = fill ? victim_way : hit_way;

    always_comb begin
        lru_d = lru_q;
        if (mark_en) begin
            for (int i = 0; i < NUM_WAYS; i++) begin
                lru_d[mark_way][i] = 1'b0;          // clear the row
            end
            for (int i = 0; i < NUM_WAYS; i++) begin
                lru_d[i][mark_way] = 1'b1;          // then set the column
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < NUM_WAYS; r++) begin
                lru_q[r] <= '1;                      // way 0 becomes the first victim
            end
        end else begin
            lru_q <= lru_d;
        end
    end

    //////////////////////////////
    // miss FSM and line state
    //////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            valid_q    <= '0;
            miss_tag_q <= '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                tags_q[w] <= '0;
            end
        end else begin
            case (state_q)
                ST_IDLE: if (read_miss) state_q <= ST_WAIT;
                ST_WAIT: if (kill_i || fill) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
            if (idle && read_miss) miss_tag_q <= req_i.tag;
            if (fill) begin
                valid_q[victim_way] <= 1'b1;
                tags_q[victim_way]  <= miss_tag_q;
            end
        end
    end

    always_comb begin
        res_o.read_hit   = read_hit;
        res_o.write_hit  = write_hit;
        res_o.hit_way    = WAY_IDX_W'(hit_way);
        res_o.refill     = fill;
        res_o.refill_way = WAY_IDX_W'(victim_way);
    end

    assign read_miss_o   = read_miss;
    assign rqst_to_mem_o = ~idle;                   // level held for the whole wait
    assign addr_to_mem_o = {miss_tag_q, {(ADDR_W - TAG_W){1'b0}}};

endmodule

//--- cache_data_array.sv
// line storage of the data cache, takes refills and write hits and registers the read data
`timescale 1ns/100ps

module cache_data_array #(
    parameter int NUM_WAYS = 4
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  cache_pkg::cache_req_t        req_i,
    input  cache_pkg::lookup_res_t       res_i,
    input  logic [cache_pkg::LINE_W-1:0] mem_line_i,
    output logic [cache_pkg::WORD_W-1:0] read_data_o,
    output logic                         read_valid_o,
    output logic                         write_hit_o
);
    import cache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    data_word_u [LINE_WORDS-1:0] lines_q [NUM_WAYS];
    logic [WAY_W-1:0]            hit_way;
    logic [WAY_W-1:0]            fill_way;
    data_word_u                  cur_word;
    data_word_u                  merged_word;
    logic [WORD_W-1:0]           rd_value;
    logic [WORD_W-1:0]           read_data_q;
    logic                        read_valid_q;
    logic                        write_hit_q;

    assign hit_way  = res_i.hit_way[WAY_W-1:0];
    assign fill_way = res_i.refill_way[WAY_W-1:0];
    assign cur_word = lines_q[hit_way][req_i.word_sel];

    //////////////////////////////
    // write merge and read select
    //////////////////////////////

    always_comb begin
        merged_word = cur_word;
        if (req_i.byte_acc) begin
            merged_word.bytes[req_i.byte_sel] = req_i.wdata[7:0];  // other bytes keep their value
        end else begin
            merged_word.word = req_i.wdata;
        end
    end

    always_comb begin
        if (req_i.byte_acc) begin
            rd_value = {{(WORD_W - 8){1'b0}}, cur_word.bytes[req_i.byte_sel]};
        end else begin
            rd_value = cur_word.word;
        end
    end

    //////////////////////////////
    // storage and output registers
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (res_i.refill) begin
            lines_q[fill_way] <= mem_line_i;            // whole line from memory
        end else if (res_i.write_hit) begin
            lines_q[hit_way][req_i.word_sel] <= merged_word;
        end
        if (res_i.read_hit) read_data_q <= rd_value;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_valid_q <= 1'b0;
            write_hit_q  <= 1'b0;
        end else begin
            read_valid_q <= res_i.read_hit;
            write_hit_q  <= res_i.write_hit;           // one cycle after the write strobe
        end
    end

    assign read_data_o  = read_data_q;
    assign read_valid_o = read_valid_q;
    assign write_hit_o  = write_hit_q;

endmodule

//--- dcache_top.sv
// top of the four-way data cache, joins decode, lookup and data array to core and memory ports
`timescale 1ns/100ps

module dcache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // core side
    input  logic                         read_rqst_i,
    input  logic                         write_enable_i,
    input  logic                         rqst_byte_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic [cache_pkg::WORD_W-1:0] wdata_i,
    input  logic                         kill_i,
    output logic [cache_pkg::WORD_W-1:0] read_data_o,
    output logic                         read_valid_o,
    output logic                         read_miss_o,
    output logic                         write_hit_o,
    output logic                         unalign_o,
    // memory side
    input  logic                         mem_data_ready_i,
    input  logic [cache_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [cache_pkg::LINE_W-1:0] mem_line_i,
    output logic                         rqst_to_mem_o,
    output logic [cache_pkg::ADDR_W-1:0] addr_to_mem_o
);
    import cache_pkg::*;

    cache_req_t  req;
    lookup_res_t res;

    cache_addr_decode decode_inst (
        .read_rqst_i   (read_rqst_i),
        .write_enable_i(write_enable_i),
        .rqst_byte_i   (rqst_byte_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .req_o         (req),
        .unalign_o     (unalign_o)
    );

    cache_lookup #(.NUM_WAYS(NUM_WAYS)) lookup_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .req_i           (req),
        .kill_i          (kill_i),
        .mem_data_ready_i(mem_data_ready_i),
        .mem_addr_i      (mem_addr_i),
        .res_o           (res),
        .read_miss_o     (read_miss_o),
        .rqst_to_mem_o   (rqst_to_mem_o),
        .addr_to_mem_o   (addr_to_mem_o)
    );

    cache_data_array #(.NUM_WAYS(NUM_WAYS)) data_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .res_i       (res),
        .mem_line_i  (mem_line_i),
        .read_data_o (read_data_o),
        .read_valid_o(read_valid_o),
        .write_hit_o (write_hit_o)
    );

endmodule

//--- dcache_assertions.sv
// checker bound into the cache top whose assertions watch pulse timing and the memory request level
`timescale 1ns/100ps

module dcache_assertions (
    input logic                         clk_i,
    input logic                         arst_n_i,
    input logic                         read_rqst_i,
    input logic                         write_enable_i,
    input logic                         kill_i,
    input logic                         unalign_i,
    input logic                         read_miss_i,
    input logic                         read_valid_i,
    input logic                         write_hit_i,
    input logic                         rqst_to_mem_i,
    input logic                         mem_data_ready_i,
    input logic [cache_pkg::ADDR_W-1:0] mem_addr_i,
    input logic [cache_pkg::ADDR_W-1:0] addr_to_mem_i
);
    import cache_pkg::*;

    logic read_hit;
    logic line_arrives;

    // an aligned read that does not miss while no refill is pending is a hit
    assign read_hit = read_rqst_i & ~unalign_i & ~read_miss_i & ~rqst_to_mem_i;

    // memory answers with the line whose address is being requested
    assign line_arrives = mem_data_ready_i &&
        (mem_addr_i[ADDR_W-1:ADDR_W-TAG_W] == addr_to_mem_i[ADDR_W-1:ADDR_W-TAG_W]);

    //////////////////////////////
    // response pulses
    //////////////////////////////

    valid_after_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        read_hit |=> read_valid_i) else $error("read valid missing after a read hit");
    no_valid_without_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !read_hit |=> !read_valid_i) else $error("read valid without a read hit");
    write_pulse_from_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        write_hit_i |-> $past(write_enable_i & ~unalign_i & ~rqst_to_mem_i))
        else $error("stray write hit pulse");

    //////////////////////////////
    // memory request
    //////////////////////////////

    idle_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !rqst_to_mem_i && !read_valid_i && !write_hit_i)
        else $error("outputs active during reset");
    request_needs_miss: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(rqst_to_mem_i) |-> $past(read_miss_i))
        else $error("memory request without a miss");
    unaligned_dropped: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        unalign_i && !rqst_to_mem_i |=> !rqst_to_mem_i)
        else $error("request on unaligned access");
    request_ends: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rqst_to_mem_i && (kill_i || line_arrives) |=> !rqst_to_mem_i)
        else $error("memory request held after kill or fill");
    request_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rqst_to_mem_i && !kill_i && !line_arrives |=> rqst_to_mem_i)
        else $error("memory request dropped early");

endmodule

bind dcache_top dcache_assertions assertions_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .read_rqst_i     (read_rqst_i),
    .write_enable_i  (write_enable_i),
    .kill_i          (kill_i),
    .unalign_i       (unalign_o),
    .read_miss_i     (read_miss_o),
    .read_valid_i    (read_valid_o),
    .write_hit_i     (write_hit_o),
    .rqst_to_mem_i   (rqst_to_mem_o),
    .mem_data_ready_i(mem_data_ready_i),
    .mem_addr_i      (mem_addr_i),
    .addr_to_mem_i   (addr_to_mem_o)
);

//--- tb_dcache.sv
// data cache testbench that plays core and memory and checks read data against the line pattern
`timescale 1ns/100ps

module tb_dcache;
    import cache_pkg::*;

    localparam int CYCLE_LIMIT = 3000;   // several times the summed length of all tests

    logic              clk;
    logic              arst_n;
    logic              read_rqst;
    logic              write_enable;
    logic              rqst_byte;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic              kill;
    logic              mem_data_ready;
    logic [ADDR_W-1:0] mem_addr;
    logic [LINE_W-1:0] mem_line;
    logic [WORD_W-1:0] read_data;
    logic              read_valid;
    logic              read_miss;
    logic              write_hit;
    logic              unalign;
    logic              rqst_to_mem;
    logic [ADDR_W-1:0] addr_to_mem;

    logic [15:0] lfsr_q       = 16'd7;
    logic [15:0] delay_lfsr_q = 16'd7;   // the memory keeps its own copy of the sequence
    int          cycle_count  = 0;
    int          check_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          start_errors = 0;
    string       test_name;

    dcache_top dcache_top_inst (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .read_rqst_i     (read_rqst),
        .write_enable_i  (write_enable),
        .rqst_byte_i     (rqst_byte),
        .addr_i          (addr),
        .wdata_i         (wdata),
        .kill_i          (kill),
        .read_data_o     (read_data),
        .read_valid_o    (read_valid),
        .read_miss_o     (read_miss),
        .write_hit_o     (write_hit),
        .unalign_o       (unalign),
        .mem_data_ready_i(mem_data_ready),
        .mem_addr_i      (mem_addr),
        .mem_line_i      (mem_line),
        .rqst_to_mem_o   (rqst_to_mem),
        .addr_to_mem_o   (addr_to_mem)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // each word of a line is built from the line tag and the word index
    function automatic logic [WORD_W-1:0] pattern_word(input logic [TAG_W-1:0] tag,
                                                       input logic [1:0] idx);
        return {tag ^ 16'h5A5A, tag[7:0], 6'b0, idx};
    endfunction

    function automatic logic [LINE_W-1:0] pattern_line(input logic [TAG_W-1:0] tag);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k*WORD_W +: WORD_W] = pattern_word(tag, 2'(k));
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [1:0] word_sel,
                                                    input logic [1:0] byte_sel);
        return {tag, word_sel, byte_sel};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %0b, actual %0b",
                     test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = check_errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (check_errors != start_errors) begin
            tests_failed++;
            $display("%s: failed", test_name);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    //////////////////////////////
    // core side accesses
    //////////////////////////////

    // holds the request until read valid, noting a miss and the line address sent to memory
    task automatic read_access(input logic [ADDR_W-1:0] a, input logic byte_acc,
                               output logic [WORD_W-1:0] data, output logic missed);
        logic done;
        missed = 1'b0;
        done   = 1'b0;
        data   = '0;
        @(posedge clk);
        read_rqst <= 1'b1;
        rqst_byte <= byte_acc;
        addr      <= a;
        while (!done) begin
            @(posedge clk);
            check_flag("unalign_o", 1'b0, unalign);
            if (read_miss) missed = 1'b1;
            if (rqst_to_mem) check_value(32'({a[ADDR_W-1:4], 4'h0}), 32'(addr_to_mem));
            if (read_valid) begin
                data = read_data;
                done = 1'b1;
            end
        end
        read_rqst <= 1'b0;
        rqst_byte <= 1'b0;
    endtask

    task automatic write_access(input logic [ADDR_W-1:0] a, input logic byte_acc,
                                input logic [WORD_W-1:0] data, output logic hit);
        @(posedge clk);
        write_enable <= 1'b1;
        rqst_byte    <= byte_acc;
        addr         <= a;
        wdata        <= data;
        @(posedge clk);
        write_enable <= 1'b0;
        rqst_byte    <= 1'b0;
        @(posedge clk);
        hit = write_hit;                         // pulse lands one cycle after the strobe
    endtask

    task automatic unaligned_probe(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        read_rqst <= 1'b1;
        rqst_byte <= 1'b0;
        addr      <= a;
        repeat (4) begin
            @(posedge clk);
            check_flag("unalign_o", 1'b1, unalign);
            check_flag("rqst_to_mem_o", 1'b0, rqst_to_mem);
            check_flag("read_valid_o", 1'b0, read_valid);
        end
        read_rqst <= 1'b0;
    endtask

    // raises kill as soon as the memory request shows and drops the read with it
    task automatic kill_miss(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        read_rqst <= 1'b1;
        rqst_byte <= 1'b0;
        addr      <= a;
        @(posedge clk);
        while (!rqst_to_mem) @(posedge clk);
        kill      <= 1'b1;
        read_rqst <= 1'b0;
        @(posedge clk);
        kill <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_flag("rqst_to_mem_o", 1'b0, rqst_to_mem);
        end
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////

    initial begin : memory_model
        logic [1:0] bits;
        int         delay;
        logic       live;
        mem_data_ready <= 1'b0;
        mem_addr       <= '0;
        mem_line       <= '0;
        forever begin
            @(posedge clk);
            if (rqst_to_mem) begin
                for (int i = 0; i < 2; i++) begin
                    bits         = {bits[0], delay_lfsr_q[0]};
                    delay_lfsr_q = lfsr_next(delay_lfsr_q);
                end
                delay = 1 + int'(bits);          // answer after 1 to 4 cycles
                live  = 1'b1;
                for (int i = 1; i < delay; i++) begin
                    @(posedge clk);
                    if (!rqst_to_mem) live = 1'b0;
                end
                if (live) begin
                    mem_data_ready <= 1'b1;
                    mem_addr       <= addr_to_mem;
                    mem_line       <= pattern_line(addr_to_mem[ADDR_W-1:4]);
                    @(posedge clk);
                    mem_data_ready <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // test sequences
    //////////////////////////////

    initial begin : stimulus
        logic [31:0]       r;
        logic [TAG_W-1:0]  base;
        logic [WORD_W-1:0] data;
        logic [WORD_W-1:0] wr_word;
        logic [7:0]        wr_byte;
        data_word_u        expect_w;
        logic              missed;
        logic              hit;
        logic [1:0]        k;
        logic [1:0]        b;

        arst_n       <= 1'b0;
        read_rqst    <= 1'b0;
        write_enable <= 1'b0;
        rqst_byte    <= 1'b0;
        addr         <= '0;
        wdata        <= '0;
        kill         <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        take_bits(16, r);
        base = r[15:0];                          // every line used below is base plus a small offset

        begin_test("read_miss_fill");
        take_bits(2, r);
        k = r[1:0];
        read_access(make_addr(base, k, 2'b00), 1'b0, data, missed);
        check_flag("read_miss_o", 1'b1, missed);
        check_value(pattern_word(base, k), data);
        end_test();

        begin_test("lru_victim");
        for (int i = 1; i < 4; i++) begin
            read_access(make_addr(base + TAG_W'(i), 2'b00, 2'b00), 1'b0, data, missed);
            check_flag("fill miss", 1'b1, missed);
        end
        read_access(make_addr(base, 2'b00, 2'b00), 1'b0, data, missed);
        check_flag("first line hit", 1'b0, missed);
        read_access(make_addr(base + 16'd4, 2'b01, 2'b00), 1'b0, data, missed);
        check_flag("fifth line miss", 1'b1, missed);
        read_access(make_addr(base + 16'd1, 2'b10, 2'b00), 1'b0, data, missed);
        check_flag("second line evicted", 1'b1, missed);
        check_value(pattern_word(base + 16'd1, 2'b10), data);
        read_access(make_addr(base, 2'b11, 2'b00), 1'b0, data, missed);
        check_flag("first line kept", 1'b0, missed);
        check_value(pattern_word(base, 2'b11), data);
        end_test();

        begin_test("byte_reads");
        take_bits(2, r);
        k = r[1:0];
        expect_w.word = pattern_word(base, k);
        for (int i = 0; i < 4; i++) begin
            b = 2'(i);
            read_access(make_addr(base, k, b), 1'b1, data, missed);
            check_flag("byte hit", 1'b0, missed);
            check_value({24'b0, expect_w.bytes[b]}, data);
        end
        end_test();

        begin_test("write_hit_and_miss");
        take_bits(32, r);
        wr_word = r;
        write_access(make_addr(base, k, 2'b00), 1'b0, wr_word, hit);
        check_flag("word write_hit_o", 1'b1, hit);
        read_access(make_addr(base, k, 2'b00), 1'b0, data, missed);
        check_value(wr_word, data);
        take_bits(2, r);
        b = r[1:0];
        take_bits(8, r);
        wr_byte = r[7:0];
        write_access(make_addr(base, k, b), 1'b1, {24'b0, wr_byte}, hit);
        check_flag("byte write_hit_o", 1'b1, hit);
        expect_w.word    = wr_word;
        expect_w.bytes[b] = wr_byte;             // only the addressed byte changes
        read_access(make_addr(base, k, 2'b00), 1'b0, data, missed);
        check_value(expect_w.word, data);
        write_access(make_addr(base + 16'd30, k, 2'b00), 1'b0, ~wr_word, hit);
        check_flag("absent write_hit_o", 1'b0, hit);
        read_access(make_addr(base + 16'd30, k, 2'b00), 1'b0, data, missed);
        check_flag("no allocate", 1'b1, missed);
        check_value(pattern_word(base + 16'd30, k), data);
        read_access(make_addr(base, k, 2'b00), 1'b0, data, missed);
        check_value(expect_w.word, data);
        end_test();

        begin_test("unaligned_word");
        take_bits(2, r);
        b = r[1:0] | 2'b01;
        unaligned_probe(make_addr(base + 16'd40, k, b));
        write_access(make_addr(base, k, b), 1'b0, wr_word, hit);
        check_flag("unaligned write_hit_o", 1'b0, hit);
        read_access(make_addr(base + 16'd40, k, b), 1'b1, data, missed);
        check_flag("byte read miss", 1'b1, missed);
        expect_w.word = pattern_word(base + 16'd40, k);
        check_value({24'b0, expect_w.bytes[b]}, data);
        end_test();

        begin_test("kill_miss");
        kill_miss(make_addr(base + 16'd50, k, 2'b00));
        read_access(make_addr(base + 16'd50, k, 2'b00), 1'b0, data, missed);
        check_flag("miss after kill", 1'b1, missed);
        check_value(pattern_word(base + 16'd50, k), data);
        end_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, check_errors);
        if (check_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
cache_pkg.sv
cache_addr_decode.sv
cache_lookup.sv
cache_data_array.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log for a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_dcache -o Vtb_dcache

./obj_dir/Vtb_dcache 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation stopped before reporting a result"
    exit 1
fi
